/* rtl/cache_pkg.sv */
/*
 * Shared types for the two-way L1 data cache. Lines hold four 32-bit words.
 * Requests are word sized and word aligned; address bits 1:0 are ignored.
 */
package cache_pkg;

  // -------------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------------

  typedef logic [31:0]  addr_t;
  typedef logic [31:0]  word_t;
  typedef logic [127:0] line_t;
  typedef logic [15:0]  wben_t;
  typedef logic [1:0]   word_sel_t;

  // -------------------------------------------------------------------------
  // Messages, shared by the cache and memory channels
  // -------------------------------------------------------------------------

  typedef enum logic {
    READ  = 1'b0,
    WRITE = 1'b1
  } req_type_e;

  typedef struct packed {
    req_type_e msg_type;
    addr_t     addr;
    word_t     data;
  } cache_req_t;

  // Data is zero for a write
  typedef struct packed {
    req_type_e msg_type;
    word_t     data;
  } cache_resp_t;

  // Address is line aligned
  typedef struct packed {
    req_type_e msg_type;
    addr_t     addr;
    line_t     data;
  } mem_req_t;

  typedef struct packed {
    req_type_e msg_type;
    line_t     data;
  } mem_resp_t;

  // -------------------------------------------------------------------------
  // Controller
  // -------------------------------------------------------------------------

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    RESP_WAIT,
    EVICT_PREPARE,
    EVICT_REQUEST,
    EVICT_WAIT,
    REFILL_REQUEST,
    REFILL_WAIT,
    REFILL_UPDATE
  } ctrl_state_e;

  typedef struct packed {
    logic      req_en;
    logic      memresp_en;
    logic      is_refill;
    logic      tag_wen;
    logic      data_wen;
    logic      read_reg_en;
    logic      victim_reg_en;
    req_type_e memreq_type;
  } dpath_ctrl_t;

  typedef struct packed {
    logic valid_wen;
    logic dirty_wen;
    logic dirty_in;
    logic lru_wen;
    logic way_record_en;
  } line_ctrl_t;

endpackage

/* rtl/cache_ctrl.sv */
/*
 * Blocking controller. One request is in flight at a time; a dirty victim
 * is written back before the refill read is issued.
 */
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cache_req_val,
  input  logic                   cache_resp_rdy,
  input  logic                   mem_req_rdy,
  input  logic                   mem_resp_val,
  input  logic                   hit,
  input  logic                   victim_dirty,
  input  cache_pkg::req_type_e   req_type,
  output logic                   cache_req_rdy,
  output logic                   cache_resp_val,
  output logic                   mem_req_val,
  output logic                   mem_resp_rdy,
  output cache_pkg::dpath_ctrl_t dpath_ctrl,
  output cache_pkg::line_ctrl_t  line_ctrl
);

  cache_pkg::ctrl_state_e state;
  cache_pkg::ctrl_state_e state_next;
  cache_pkg::ctrl_state_e access_state;

  // -------------------------------------------------------------------------
  // State register
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Both a hit and a finished refill continue into the data access
  assign access_state = (req_type == cache_pkg::WRITE) ? cache_pkg::WRITE_ACCESS
                                                       : cache_pkg::READ_ACCESS;

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::IDLE: begin
        if (cache_req_val) begin
          state_next = cache_pkg::TAG_CHECK;
        end
      end
      cache_pkg::TAG_CHECK: begin
        if (hit) begin
          state_next = access_state;
        end else if (victim_dirty) begin
          state_next = cache_pkg::EVICT_PREPARE;
        end else begin
          state_next = cache_pkg::REFILL_REQUEST;
        end
      end
      cache_pkg::READ_ACCESS,
      cache_pkg::WRITE_ACCESS: state_next = cache_pkg::RESP_WAIT;
      cache_pkg::RESP_WAIT: begin
        if (cache_resp_rdy) begin
          state_next = cache_pkg::IDLE;
        end
      end
      cache_pkg::EVICT_PREPARE: state_next = cache_pkg::EVICT_REQUEST;
      cache_pkg::EVICT_REQUEST: begin
        if (mem_req_rdy) begin
          state_next = cache_pkg::EVICT_WAIT;
        end
      end
      cache_pkg::EVICT_WAIT: begin
        // Write acknowledgment, then fetch the new line
        if (mem_resp_val) begin
          state_next = cache_pkg::REFILL_REQUEST;
        end
      end
      cache_pkg::REFILL_REQUEST: begin
        if (mem_req_rdy) begin
          state_next = cache_pkg::REFILL_WAIT;
        end
      end
      cache_pkg::REFILL_WAIT: begin
        if (mem_resp_val) begin
          state_next = cache_pkg::REFILL_UPDATE;
        end
      end
      cache_pkg::REFILL_UPDATE: state_next = access_state;
      default: state_next = cache_pkg::IDLE;
    endcase
  end

  // -------------------------------------------------------------------------
  // Outputs per state
  // -------------------------------------------------------------------------

  always_comb begin
    cache_req_rdy          = 1'b0;
    cache_resp_val         = 1'b0;
    mem_req_val            = 1'b0;
    mem_resp_rdy           = 1'b0;
    dpath_ctrl             = '0;
    dpath_ctrl.memreq_type = cache_pkg::READ;
    line_ctrl              = '0;
    case (state)
      cache_pkg::IDLE: begin
        cache_req_rdy     = 1'b1;
        dpath_ctrl.req_en = 1'b1;
      end
      cache_pkg::TAG_CHECK: line_ctrl.way_record_en = 1'b1;
      cache_pkg::READ_ACCESS: begin
        dpath_ctrl.read_reg_en = 1'b1;
        line_ctrl.lru_wen      = 1'b1;
      end
      cache_pkg::WRITE_ACCESS: begin
        dpath_ctrl.data_wen = 1'b1;
        line_ctrl.dirty_wen = 1'b1;
        line_ctrl.dirty_in  = 1'b1;
        line_ctrl.lru_wen   = 1'b1;
      end
      cache_pkg::RESP_WAIT: cache_resp_val = 1'b1;
      cache_pkg::EVICT_PREPARE: dpath_ctrl.victim_reg_en = 1'b1;
      cache_pkg::EVICT_REQUEST: begin
        mem_req_val            = 1'b1;
        dpath_ctrl.memreq_type = cache_pkg::WRITE;
      end
      cache_pkg::EVICT_WAIT: mem_resp_rdy = 1'b1;
      cache_pkg::REFILL_REQUEST: mem_req_val = 1'b1;
      cache_pkg::REFILL_WAIT: begin
        mem_resp_rdy          = 1'b1;
        dpath_ctrl.memresp_en = 1'b1;
      end
      cache_pkg::REFILL_UPDATE: begin
        // New line is valid and clean
        dpath_ctrl.is_refill = 1'b1;
        dpath_ctrl.tag_wen   = 1'b1;
        dpath_ctrl.data_wen  = 1'b1;
        line_ctrl.valid_wen  = 1'b1;
        line_ctrl.dirty_wen  = 1'b1;
      end
      default: cache_req_rdy = 1'b0;
    endcase
  end

endmodule

/* rtl/cache_line_state.sv */
/*
 * Per-set valid, dirty and LRU bits for two ways. num_sets must be a power
 * of two, at least 2. The way chosen in tag check is held until the next one.
 */
`timescale 1ns/1ps

module cache_line_state #(
  parameter int num_sets = 8
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [$clog2(num_sets)-1:0] idx,
  input  logic                        tag_match_0,
  input  logic                        tag_match_1,
  input  cache_pkg::line_ctrl_t       line_ctrl,
  output logic                        hit,
  output logic                        victim_dirty,
  output logic                        way
);

  // Outer index is the way
  logic [1:0][num_sets-1:0] valid_bits;
  logic [1:0][num_sets-1:0] dirty_bits;
  // Set bit names the way to replace next
  logic [num_sets-1:0]      lru_bits;

  logic hit_0;
  logic hit_1;
  logic lru_way;
  logic way_next;

  // -------------------------------------------------------------------------
  // Hit detection and victim choice
  // -------------------------------------------------------------------------

  assign hit_0   = valid_bits[0][idx] && tag_match_0;
  assign hit_1   = valid_bits[1][idx] && tag_match_1;
  assign hit     = hit_0 || hit_1;
  assign lru_way = lru_bits[idx];

  assign victim_dirty = dirty_bits[lru_way][idx];

  // On a hit, hit_1 alone tells the way; a miss takes the LRU way
  assign way_next = hit ? hit_1 : lru_way;

  // -------------------------------------------------------------------------
  // State updates
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      lru_bits   <= '0;
      way        <= 1'b0;
    end else begin
      if (line_ctrl.way_record_en) begin
        way <= way_next;
      end
      if (line_ctrl.valid_wen) begin
        valid_bits[way][idx] <= 1'b1;
      end
      if (line_ctrl.dirty_wen) begin
        dirty_bits[way][idx] <= line_ctrl.dirty_in;
      end
      if (line_ctrl.lru_wen) begin
        lru_bits[idx] <= !way;
      end
    end
  end

endmodule

/* rtl/cache_dpath.sv */
/*
 * Cache datapath with flop-based tag and data arrays read combinationally.
 * Sets are indexed by the address bits just above the 16-byte line offset.
 */
`timescale 1ns/1ps

module cache_dpath #(
  parameter int num_sets = 8
) (
  input  logic                        clk,
  input  cache_pkg::cache_req_t       cache_req,
  input  cache_pkg::mem_resp_t        mem_resp,
  input  cache_pkg::dpath_ctrl_t      dpath_ctrl,
  input  logic                        way,
  output logic [$clog2(num_sets)-1:0] idx,
  output cache_pkg::req_type_e        req_type,
  output logic                        tag_match_0,
  output logic                        tag_match_1,
  output cache_pkg::cache_resp_t      cache_resp,
  output cache_pkg::mem_req_t         mem_req
);

  localparam int idx_w = $clog2(num_sets);
  localparam int tag_w = 32 - idx_w - 4;

  typedef logic [tag_w-1:0] tag_t;

  cache_pkg::cache_req_t req_reg;
  cache_pkg::line_t      memresp_line;
  cache_pkg::word_t      read_reg;
  cache_pkg::line_t      victim_line;
  tag_t                  victim_tag;

  tag_t                  req_tag;
  cache_pkg::word_sel_t  word_sel;
  cache_pkg::line_t      rd_line;
  cache_pkg::wben_t      wben;
  cache_pkg::line_t      wdata;

  // Arrays, outer index is the way
  tag_t             tag_array [2][num_sets];
  cache_pkg::line_t data_array [2][num_sets];

  // -------------------------------------------------------------------------
  // Request and memory response registers
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (dpath_ctrl.req_en) begin
      req_reg <= cache_req;
    end
    if (dpath_ctrl.memresp_en) begin
      memresp_line <= mem_resp.data;
    end
  end

  assign idx      = req_reg.addr[4 +: idx_w];
  assign req_tag  = req_reg.addr[31 -: tag_w];
  assign word_sel = req_reg.addr[3:2];
  assign req_type = req_reg.msg_type;

  // -------------------------------------------------------------------------
  // Tag arrays
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (dpath_ctrl.tag_wen) begin
      tag_array[way][idx] <= req_tag;
    end
  end

  assign tag_match_0 = (tag_array[0][idx] == req_tag);
  assign tag_match_1 = (tag_array[1][idx] == req_tag);

  // -------------------------------------------------------------------------
  // Data arrays
  // -------------------------------------------------------------------------

  // Refill writes the whole line, a store only its own word
  always_comb begin
    if (dpath_ctrl.is_refill) begin
      wben  = '1;
      wdata = memresp_line;
    end else begin
      wben  = 16'h000f << {word_sel, 2'b00};
      wdata = {4{req_reg.data}};
    end
  end

  always_ff @(posedge clk) begin
    if (dpath_ctrl.data_wen) begin
      for (int b = 0; b < 16; b++) begin
        if (wben[b]) begin
          data_array[way][idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  assign rd_line = data_array[way][idx];

  // Read word and victim capture
  always_ff @(posedge clk) begin
    if (dpath_ctrl.read_reg_en) begin
      read_reg <= rd_line[{word_sel, 5'b00000} +: 32];
    end
    if (dpath_ctrl.victim_reg_en) begin
      victim_line <= rd_line;
      victim_tag  <= tag_array[way][idx];
    end
  end

  // -------------------------------------------------------------------------
  // Outgoing messages
  // -------------------------------------------------------------------------

  always_comb begin
    cache_resp.msg_type = req_reg.msg_type;
    if (req_reg.msg_type == cache_pkg::READ) begin
      cache_resp.data = read_reg;
    end else begin
      cache_resp.data = '0;
    end
  end

  // Eviction writes the victim line back; refill reads the request's line
  always_comb begin
    mem_req.msg_type = dpath_ctrl.memreq_type;
    if (dpath_ctrl.memreq_type == cache_pkg::WRITE) begin
      mem_req.addr = {victim_tag, idx, 4'b0000};
      mem_req.data = victim_line;
    end else begin
      mem_req.addr = {req_tag, idx, 4'b0000};
      mem_req.data = '0;
    end
  end

endmodule

/* rtl/cache_top.sv */
/*
 * Two-way write-back L1 data cache with valid/ready channels on both sides.
 * num_sets must be a power of two, at least 2.
 */
`timescale 1ns/1ps

module cache_top #(
  parameter int num_sets = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cache_req_val,
  input  cache_pkg::cache_req_t  cache_req,
  input  logic                   cache_resp_rdy,
  input  logic                   mem_req_rdy,
  input  logic                   mem_resp_val,
  input  cache_pkg::mem_resp_t   mem_resp,
  output logic                   cache_req_rdy,
  output logic                   cache_resp_val,
  output cache_pkg::cache_resp_t cache_resp,
  output logic                   mem_req_val,
  output cache_pkg::mem_req_t    mem_req,
  output logic                   mem_resp_rdy
);

  localparam int idx_w = $clog2(num_sets);

  cache_pkg::dpath_ctrl_t dpath_ctrl;
  cache_pkg::line_ctrl_t  line_ctrl;
  cache_pkg::req_type_e   req_type;
  logic [idx_w-1:0]       idx;
  logic                   tag_match_0;
  logic                   tag_match_1;
  logic                   hit;
  logic                   victim_dirty;
  logic                   way;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cache_req_val  (cache_req_val),
    .cache_resp_rdy (cache_resp_rdy),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp_val   (mem_resp_val),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .req_type       (req_type),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp_val (cache_resp_val),
    .mem_req_val    (mem_req_val),
    .mem_resp_rdy   (mem_resp_rdy),
    .dpath_ctrl     (dpath_ctrl),
    .line_ctrl      (line_ctrl)
  );

  cache_line_state #(.num_sets(num_sets)) u_line_state (
    .clk          (clk),
    .reset        (reset),
    .idx          (idx),
    .tag_match_0  (tag_match_0),
    .tag_match_1  (tag_match_1),
    .line_ctrl    (line_ctrl),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .way          (way)
  );

  cache_dpath #(.num_sets(num_sets)) u_dpath (
    .clk         (clk),
    .cache_req   (cache_req),
    .mem_resp    (mem_resp),
    .dpath_ctrl  (dpath_ctrl),
    .way         (way),
    .idx         (idx),
    .req_type    (req_type),
    .tag_match_0 (tag_match_0),
    .tag_match_1 (tag_match_1),
    .cache_resp  (cache_resp),
    .mem_req     (mem_req)
  );

endmodule

/* bench/cache_tb_mem.sv */
/*
 * Behavioral main memory of 4 KB for the cache testbench. Higher address
 * bits are ignored. One request is served at a time, with random stalls.
 */
`timescale 1ns/1ps

module cache_tb_mem (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_req_val,
  input  cache_pkg::mem_req_t  mem_req,
  output logic                 mem_req_rdy,
  output logic                 mem_resp_val,
  output cache_pkg::mem_resp_t mem_resp,
  input  logic                 mem_resp_rdy
);

  cache_pkg::word_t words [1024];
  logic [7:0]       lfsr;
  logic             busy;

  // Fibonacci LFSR, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic random_bit();
    logic fb;
    fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    lfsr = {lfsr[6:0], fb};
    return fb;
  endfunction

  // Write stores the line, read returns it
  task automatic serve(input cache_pkg::mem_req_t req);
    mem_resp.msg_type = req.msg_type;
    mem_resp.data = '0;
    for (int w = 0; w < 4; w++) begin
      if (req.msg_type == cache_pkg::WRITE) begin
        words[{req.addr[11:4], 2'(w)}] = req.data[32*w +: 32];
      end else begin
        mem_resp.data[32*w +: 32] = words[{req.addr[11:4], 2'(w)}];
      end
    end
  endtask

  initial begin
    logic [9:0]          w;
    logic                in_reset;
    logic                accepted;
    cache_pkg::mem_req_t req_q;
    lfsr = 8'd86;
    busy = 1'b0;
    mem_req_rdy = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp = '0;
    w = '0;
    repeat (1024) begin
      words[w] = {20'h0, w, 2'b00} ^ 32'hA5A5_0000;
      w++;
    end
    forever begin
      @(posedge clk);
      in_reset = reset;
      accepted = !in_reset && mem_req_val && mem_req_rdy;
      if (in_reset || (mem_resp_val && mem_resp_rdy)) begin
        busy = 1'b0;
      end
      req_q = mem_req;
      #1;
      if (accepted) begin
        serve(req_q);
        busy = 1'b1;
      end
      // A raised valid stays up until the transfer
      mem_resp_val = busy && (mem_resp_val || random_bit());
      mem_req_rdy = !in_reset && !busy && random_bit();
    end
  end

endmodule

/* bench/cache_tb.sv */
/*
 * Testbench for the two-way cache. All addresses stay below 4 KB, the size
 * of the memory model and of the shadow memory.
 */
`timescale 1ns/1ps

module cache_tb;

  localparam int timeout_cycles = 500;

  logic                   clk;
  logic                   reset;
  logic                   cache_req_val;
  cache_pkg::cache_req_t  cache_req;
  logic                   cache_req_rdy;
  logic                   cache_resp_val;
  logic                   cache_resp_rdy;
  cache_pkg::cache_resp_t cache_resp;
  logic                   mem_req_val;
  logic                   mem_req_rdy;
  cache_pkg::mem_req_t    mem_req;
  logic                   mem_resp_val;
  logic                   mem_resp_rdy;
  cache_pkg::mem_resp_t   mem_resp;

  // Reference values for the running request
  cache_pkg::word_t       shadow [1024];
  cache_pkg::req_type_e   exp_type;
  cache_pkg::word_t       exp_data;
  logic                   exp_hit;
  logic                   mem_check_en;
  cache_pkg::word_t       mem_word;
  cache_pkg::word_t       shadow_word;

  // Values from the previous edge
  logic                   reset_d;
  logic                   resp_stall_d;
  logic                   memreq_stall_d;
  cache_pkg::cache_resp_t resp_d;
  cache_pkg::mem_req_t    memreq_d;
  logic                   mem_pending;

  logic [7:0]             lfsr;
  int                     value_errors;
  int                     timeouts;

  cache_top #(.num_sets(8)) dut_i (
    .clk            (clk),
    .reset          (reset),
    .cache_req_val  (cache_req_val),
    .cache_req      (cache_req),
    .cache_resp_rdy (cache_resp_rdy),
    .mem_req_rdy    (mem_req_rdy),
    .mem_resp_val   (mem_resp_val),
    .mem_resp       (mem_resp),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp_val (cache_resp_val),
    .cache_resp     (cache_resp),
    .mem_req_val    (mem_req_val),
    .mem_req        (mem_req),
    .mem_resp_rdy   (mem_resp_rdy)
  );

  cache_tb_mem mem_i (
    .clk          (clk),
    .reset        (reset),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .mem_resp_rdy (mem_resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    reset_d <= reset;
    resp_stall_d <= cache_resp_val && !cache_resp_rdy;
    resp_d <= cache_resp;
    memreq_stall_d <= mem_req_val && !mem_req_rdy;
    memreq_d <= mem_req;
    if (reset) begin
      mem_pending <= 1'b0;
    end else if (mem_req_val && mem_req_rdy) begin
      mem_pending <= 1'b1;
    end else if (mem_resp_val && mem_resp_rdy) begin
      mem_pending <= 1'b0;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Every edge in reset and the first one after it
  assert property (@(posedge clk) reset_d |-> cache_req_rdy && !cache_resp_val && !mem_req_val)
    else begin
      value_errors++;
      $display("ERR reset outputs cache_req_rdy=%h cache_resp_val=%h mem_req_val=%h",
               $sampled(cache_req_rdy), $sampled(cache_resp_val), $sampled(mem_req_val));
    end

  assert property (@(posedge clk) cache_resp_val && cache_resp_rdy |->
                   cache_resp.msg_type == exp_type)
    else begin
      value_errors++;
      $display("ERR cache_resp.msg_type exp %h got %h", $sampled(exp_type),
               $sampled(cache_resp.msg_type));
    end

  assert property (@(posedge clk) cache_resp_val && cache_resp_rdy |->
                   cache_resp.data == exp_data)
    else begin
      value_errors++;
      $display("ERR cache_resp.data exp %h got %h", $sampled(exp_data),
               $sampled(cache_resp.data));
    end

  assert property (@(posedge clk) $past(cache_req_val && cache_req_rdy && exp_hit, 3) |->
                   cache_resp_val && !$past(cache_resp_val))
    else begin
      value_errors++;
      $display("Hit response did not rise exactly 3 cycles after acceptance");
    end

  assert property (@(posedge clk) resp_stall_d |-> cache_resp_val && cache_resp == resp_d)
    else begin
      value_errors++;
      $display("ERR cache_resp under stall was %h now val=%h data=%h", $sampled(resp_d),
               $sampled(cache_resp_val), $sampled(cache_resp));
    end

  assert property (@(posedge clk) memreq_stall_d |-> mem_req_val && mem_req == memreq_d)
    else begin
      value_errors++;
      $display("ERR mem_req under stall was %h now val=%h data=%h", $sampled(memreq_d),
               $sampled(mem_req_val), $sampled(mem_req));
    end

  // Memory responses are taken only while a memory request is outstanding
  assert property (@(posedge clk) !reset && mem_resp_rdy |-> mem_pending)
    else begin
      value_errors++;
      $display("ERR mem_resp_rdy=%h with no memory request outstanding",
               $sampled(mem_resp_rdy));
    end

  assert property (@(posedge clk) mem_check_en |-> mem_word == shadow_word)
    else begin
      value_errors++;
      $display("ERR memory word exp %h got %h", $sampled(shadow_word), $sampled(mem_word));
    end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Fibonacci LFSR with taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic random_bit();
    logic fb;
    fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    lfsr = {lfsr[6:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], random_bit()};
    end
    return r;
  endfunction

  task automatic finish_run();
    $display("Checks done with %0d value errors and %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    timeouts++;
    $display("Timeout: %s", what);
    finish_run();
  endtask

  // Runs one request from issue to accepted response
  task automatic run_access(input cache_pkg::req_type_e kind, input cache_pkg::addr_t addr,
                            input cache_pkg::word_t data, input logic hit);
    int waited;
    exp_type = kind;
    exp_data = (kind == cache_pkg::WRITE) ? '0 : shadow[addr[11:2]];
    exp_hit = hit;
    cache_req.msg_type = kind;
    cache_req.addr = addr;
    cache_req.data = data;
    cache_req_val = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!cache_req_rdy) begin
      waited++;
      if (waited > timeout_cycles) stop_on_timeout("cache never became ready for a request");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cache_req_val = 1'b0;
    if (kind == cache_pkg::WRITE) shadow[addr[11:2]] = data;
    waited = 0;
    cache_resp_rdy = random_bit();
    @(negedge clk);
    while (!(cache_resp_val && cache_resp_rdy)) begin
      waited++;
      if (waited > timeout_cycles) stop_on_timeout("no response from the cache");
      @(posedge clk);
      #1;
      cache_resp_rdy = random_bit();
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cache_resp_rdy = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin
    logic [9:0]  w;
    logic [31:0] r;
    cache_pkg::addr_t addr;
    lfsr = 8'd86;
    value_errors = 0;
    timeouts = 0;
    reset = 1'b1;
    cache_req_val = 1'b0;
    cache_req = '0;
    cache_resp_rdy = 1'b0;
    exp_type = cache_pkg::READ;
    exp_data = '0;
    exp_hit = 1'b0;
    mem_check_en = 1'b0;
    mem_word = '0;
    shadow_word = '0;
    reset_d = 1'b0;
    resp_stall_d = 1'b0;
    memreq_stall_d = 1'b0;
    mem_pending = 1'b0;
    w = '0;
    repeat (1024) begin
      shadow[w] = {20'h0, w, 2'b00} ^ 32'hA5A5_0000;
      w++;
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Cold read and then the same word as a hit
    run_access(cache_pkg::READ, 32'h0000_0040, '0, 1'b0);
    run_access(cache_pkg::READ, 32'h0000_0040, '0, 1'b1);
    run_access(cache_pkg::WRITE, 32'h0000_0044, 32'h1234_5678, 1'b1);
    run_access(cache_pkg::READ, 32'h0000_0044, '0, 1'b1);

    // Three lines of set 0; the third write evicts the dirty line at 0x100
    run_access(cache_pkg::WRITE, 32'h0000_0100, 32'hCAFE_0001, 1'b0);
    run_access(cache_pkg::WRITE, 32'h0000_0180, 32'hCAFE_0002, 1'b0);
    run_access(cache_pkg::WRITE, 32'h0000_0200, 32'hCAFE_0003, 1'b0);
    addr = 32'h0000_0100;
    mem_word = mem_i.words[addr[11:2]];
    shadow_word = shadow[addr[11:2]];
    mem_check_en = 1'b1;
    @(posedge clk);
    #1;
    mem_check_en = 1'b0;
    run_access(cache_pkg::READ, addr, '0, 1'b0);

    // 64 words over sets 0 and 4
    repeat (200) begin
      r = random_bits(7);
      addr = {22'h0, r[5:2], 2'b00, r[1:0], 2'b00};
      if (r[6]) begin
        run_access(cache_pkg::WRITE, addr, random_bits(32), 1'b0);
      end else begin
        run_access(cache_pkg::READ, addr, '0, 1'b0);
      end
    end
    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule

/* build.f */
rtl/cache_pkg.sv
rtl/cache_ctrl.sv
rtl/cache_line_state.sv
rtl/cache_dpath.sv
rtl/cache_top.sv
bench/cache_tb_mem.sv
bench/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cache_tb -f build.f -Mdir obj_dir \
  && ./obj_dir/Vcache_tb > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
